//--- hdl/adc_slice_pkg.sv
package adc_slice_pkg;

    // unsigned code and TDC chain widths.
    localparam int NADC = 8;
    localparam int NTHM = (2 ** NADC) - 1;

    // popcount grouping in the adder.
    localparam int NGRP = 16;
    localparam int GRP_W = 16;
    localparam int GRP_CNT_W = $clog2(GRP_W) + 1;

    // output buffer and flow control.
    localparam int FIFO_DEPTH = 4;
    localparam int CREDIT_MAX = 4;
    localparam int FILL_W = $clog2(FIFO_DEPTH) + 1;

    // raw delay-chain flops.
    typedef logic [NTHM-1:0] tdc_word_t;

    // count of ones in the chain.
    typedef logic [NADC-1:0] code_t;

    // sign folded in, two's complement.
    typedef logic signed [NADC:0] sample_t;

    // 0 to CREDIT_MAX.
    typedef logic [2:0] credit_t;

    // retimer buffer index.
    typedef logic [1:0] fifo_ptr_t;

    // per-group partial count.
    typedef logic [GRP_CNT_W-1:0] grp_cnt_t;

endpackage

//--- hdl/tdc_capture.sv
module tdc_capture
    import adc_slice_pkg::*;
(
    input  logic      clk_adder,
    input  logic      rstb,
    input  tdc_word_t tdc_word,
    input  logic      tdc_sign,
    input  logic      tdc_valid,
    input  logic      en_phase_reverse,
    output tdc_word_t cap_word,
    output logic      cap_sign,
    output logic      cap_valid
);

    logic ph_rev_meta;  // first sync flop.
    logic ph_rev_sync;  // safe to use.

    tdc_word_t word_fix;

    // en_phase_reverse comes from a slow control register, no relation to clk_adder.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            ph_rev_meta <= 1'b0;
            ph_rev_sync <= 1'b0;
        end else begin
            ph_rev_meta <= en_phase_reverse;
            ph_rev_sync <= ph_rev_meta;
        end
    end

    // reversed phase flips every chain flop.
    always_comb begin
        if (ph_rev_sync) begin
            word_fix = ~tdc_word;
        end else begin
            word_fix = tdc_word;
        end
    end

    always_ff @(posedge clk_adder) begin
        if (tdc_valid) begin
            cap_word <= word_fix;
            cap_sign <= tdc_sign;
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= tdc_valid;
        end
    end

endmodule

//--- hdl/wallace_adder.sv
module wallace_adder
    import adc_slice_pkg::*;
(
    input  logic      clk_adder,
    input  logic      rstb,
    input  tdc_word_t cap_word,
    input  logic      cap_sign,
    input  logic      cap_valid,
    output code_t     sum_code,
    output logic      sum_sign,
    output logic      sum_valid
);

    localparam int PAD_W = NGRP * GRP_W;

    logic [PAD_W-1:0] word_pad;

    grp_cnt_t grp_cnt_d [NGRP];
    grp_cnt_t grp_cnt_q [NGRP];

    logic sign_s1;
    logic valid_s1;

    // tree levels, one bit wider each.
    logic [GRP_CNT_W:0]   lvl1 [NGRP/2];
    logic [GRP_CNT_W+1:0] lvl2 [NGRP/4];
    logic [GRP_CNT_W+2:0] lvl3 [NGRP/8];
    code_t                total;

    function automatic grp_cnt_t pop16(input logic [GRP_W-1:0] bits);
        grp_cnt_t cnt;
        cnt = '0;
        for (int k = 0; k < GRP_W; k++) begin
            cnt = cnt + grp_cnt_t'(bits[k]);
        end
        return cnt;
    endfunction

    // top bit is a pad so the last group is 15 wide.
    assign word_pad = {{(PAD_W - NTHM){1'b0}}, cap_word};

    always_comb begin
        for (int g = 0; g < NGRP; g++) begin
            grp_cnt_d[g] = pop16(word_pad[g*GRP_W +: GRP_W]);
        end
    end

    // stage one.
    always_ff @(posedge clk_adder) begin
        for (int g = 0; g < NGRP; g++) begin
            grp_cnt_q[g] <= grp_cnt_d[g];
        end
        sign_s1 <= cap_sign;
    end

    // adder tree on the registered partial counts
    always_comb begin
        for (int i = 0; i < NGRP / 2; i++) begin
            lvl1[i] = {1'b0, grp_cnt_q[2*i]} + {1'b0, grp_cnt_q[2*i+1]};
        end
        for (int i = 0; i < NGRP / 4; i++) begin
            lvl2[i] = {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
        end
        for (int i = 0; i < NGRP / 8; i++) begin
            lvl3[i] = {1'b0, lvl2[2*i]} + {1'b0, lvl2[2*i+1]};
        end
        total = lvl3[0] + lvl3[1];  // never above 255.
    end

    // stage two.
    always_ff @(posedge clk_adder) begin
        sum_code <= total;
        sum_sign <= sign_s1;
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            valid_s1  <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            valid_s1  <= cap_valid;
            sum_valid <= valid_s1;
        end
    end

endmodule

//--- hdl/adc_retimer.sv
module adc_retimer
    import adc_slice_pkg::*;
(
    input  logic    clk_adder,
    input  logic    rstb,
    input  code_t   sum_code,
    input  logic    sum_sign,
    input  logic    sum_valid,
    input  logic    credit_return,
    output sample_t sample_out,
    output logic    sample_valid,
    output logic    overflow
);

    sample_t sample_in;
    sample_t mem [FIFO_DEPTH];

    fifo_ptr_t          wr_ptr;
    fifo_ptr_t          rd_ptr;
    logic [FILL_W-1:0]  fill_cnt;
    credit_t            credits;

    logic full;
    logic wr_en;
    logic pop;

    // sign-magnitude to two's complement.
    always_comb begin
        if (sum_sign) begin
            sample_in = -sample_t'({1'b0, sum_code});
        end else begin
            sample_in = sample_t'({1'b0, sum_code});
        end
    end

    assign full  = (fill_cnt == FILL_W'(FIFO_DEPTH));
    assign wr_en = sum_valid && !full;
    assign pop   = (fill_cnt != '0) && (credits != '0);

    always_ff @(posedge clk_adder) begin
        if (wr_en) begin
            mem[wr_ptr] <= sample_in;
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);  // wraps at depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
            case ({wr_en, pop})
                2'b10:   fill_cnt <= fill_cnt + FILL_W'(1);
                2'b01:   fill_cnt <= fill_cnt - FILL_W'(1);
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // send stage.
    always_ff @(posedge clk_adder) begin
        if (pop) begin
            sample_out <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= pop;
        end
    end

    // one credit spent per pop, one back per return pulse.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            credits <= credit_t'(CREDIT_MAX);
        end else begin
            case ({pop, credit_return})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

    // sticky until reset.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            overflow <= 1'b0;
        end else if (sum_valid && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

//--- hdl/adc_slice_backend.sv
module adc_slice_backend
    import adc_slice_pkg::*;
(
    input  logic      clk_adder,
    input  logic      rstb,
    input  tdc_word_t tdc_word,
    input  logic      tdc_sign,
    input  logic      tdc_valid,
    input  logic      en_phase_reverse,
    input  logic      credit_return,
    output sample_t   sample_out,
    output logic      sample_valid,
    output logic      overflow
);

    tdc_word_t cap_word;
    logic      cap_sign;
    logic      cap_valid;

    code_t     sum_code;
    logic      sum_sign;
    logic      sum_valid;

    tdc_capture icapture (
        .clk_adder        (clk_adder),
        .rstb             (rstb),
        .tdc_word         (tdc_word),
        .tdc_sign         (tdc_sign),
        .tdc_valid        (tdc_valid),
        .en_phase_reverse (en_phase_reverse),
        .cap_word         (cap_word),
        .cap_sign         (cap_sign),
        .cap_valid        (cap_valid)
    );

    wallace_adder iadder (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .cap_word  (cap_word),
        .cap_sign  (cap_sign),
        .cap_valid (cap_valid),
        .sum_code  (sum_code),
        .sum_sign  (sum_sign),
        .sum_valid (sum_valid)
    );

    adc_retimer iretimer (
        .clk_adder     (clk_adder),
        .rstb          (rstb),
        .sum_code      (sum_code),
        .sum_sign      (sum_sign),
        .sum_valid     (sum_valid),
        .credit_return (credit_return),
        .sample_out    (sample_out),
        .sample_valid  (sample_valid),
        .overflow      (overflow)
    );

endmodule

//--- tb/tb_adc_slice.sv
module tb_adc_slice
    import adc_slice_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS = 28;
    localparam int PROMPT = 0;
    localparam int HOLD = 1;
    localparam int LATENCY = 4;      // accepting edge to sample_valid.
    localparam int FILL_CYCLES = 4;  // last accept until written or dropped.

    // one column per field and one entry per row.
    localparam int LEVEL_TBL [NROWS] = '{
        0, 1, 128, 255, 0, 255, 128, 1, 77,
        10, 200, 255, 0, 10, 200,
        3, 250, 17, 99, 128, 64, 1, 254, 33, 180,
        42, 43, 5
    };
    localparam int SIGN_TBL [NROWS] = '{
        0, 1, 0, 1, 1, 0, 1, 0, 1,
        0, 1, 0, 1, 0, 1,
        0, 1, 0, 1, 0, 1, 0, 1, 0, 1,
        1, 0, 1
    };
    localparam int REV_TBL [NROWS] = '{
        0, 0, 0, 0, 0, 0, 0, 0, 0,
        1, 1, 1, 1, 0, 0,
        0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
        0, 0, 0
    };
    localparam int IDLE_TBL [NROWS] = '{
        2, 3, 5, 5, 6, 0, 0, 0, 4,
        4, 0, 2, 0, 4, 0,
        2, 0, 0, 0, 0, 0, 0, 0, 0, 0,
        3, 0, 2
    };
    localparam int MODE_TBL [NROWS] = '{
        PROMPT, PROMPT, PROMPT, PROMPT, PROMPT, PROMPT, PROMPT, PROMPT, PROMPT,
        PROMPT, PROMPT, PROMPT, PROMPT, PROMPT, PROMPT,
        HOLD, HOLD, HOLD, HOLD, HOLD, HOLD, HOLD, HOLD, HOLD, HOLD,
        PROMPT, PROMPT, PROMPT
    };

    logic      clk_adder;
    logic      rstb;
    tdc_word_t tdc_word;
    logic      tdc_sign;
    logic      tdc_valid;
    logic      en_phase_reverse;
    logic      credit_return;
    sample_t   sample_out;
    logic      sample_valid;
    logic      overflow;

    sample_t exp_q [$];
    int      acc_q [$];  // cycle of the accepting edge.
    bit      lat_q [$];

    int   cycle_cnt;
    int   cycle_limit;
    int   avail;         // DUT credits as the sink sees them.
    int   owed;
    logic hold_credits;
    logic exp_overflow;
    int   block_cnt;

    adc_slice_backend uut (
        .clk_adder        (clk_adder),
        .rstb             (rstb),
        .tdc_word         (tdc_word),
        .tdc_sign         (tdc_sign),
        .tdc_valid        (tdc_valid),
        .en_phase_reverse (en_phase_reverse),
        .credit_return    (credit_return),
        .sample_out       (sample_out),
        .sample_valid     (sample_valid),
        .overflow         (overflow)
    );

    always #2 clk_adder = ~clk_adder;

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_sample(input sample_t exp, input sample_t act, input string name);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string name);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp) begin
            $display("FAIL t=%0t sample_valid latency expected %0d actual %0d",
                     $time, exp, act);
            stop_run();
        end
    endtask

    function automatic int timeout_limit();
        int total;
        total = 100;
        for (int r = 0; r < NROWS; r++) begin
            total += IDLE_TBL[r] + 10;
        end
        return total;
    endfunction

    // exactly level ones at shuffled positions to model bubbles.
    function automatic tdc_word_t build_word(input int level);
        int        pos [NTHM];
        tdc_word_t w;
        int        j;
        int        tmp;
        for (int i = 0; i < NTHM; i++) begin
            pos[i] = i;
        end
        w = '0;
        for (int i = 0; i < level; i++) begin
            j = i + int'($urandom_range(NTHM - 1 - i));
            tmp = pos[i];
            pos[i] = pos[j];
            pos[j] = tmp;
            w[pos[i]] = 1'b1;
        end
        return w;
    endfunction

    task automatic idle_cycle();
        @(negedge clk_adder);
        tdc_valid = 1'b0;
    endtask

    // ends on a rising edge.
    task automatic wait_drained(input bit all_credits);
        @(posedge clk_adder);
        while (exp_q.size() != 0 || (all_credits && avail != CREDIT_MAX)) begin
            @(posedge clk_adder);
        end
    endtask

    task automatic start_hold();
        idle_cycle();
        wait_drained(1'b1);
        hold_credits = 1'b1;
        block_cnt = 0;
        idle_cycle();
        check_flag(1'b0, overflow, "overflow");
    endtask

    task automatic end_hold();
        repeat (FILL_CYCLES) idle_cycle();
        check_flag(exp_overflow, overflow, "overflow");
        check_flag(1'b0, sample_valid, "sample_valid");
        @(posedge clk_adder);
        hold_credits = 1'b0;
        wait_drained(1'b0);  // held samples leave in order.
    endtask

    task automatic run_row(input int r);
        int cnt;
        int val;
        if (MODE_TBL[r] == HOLD && !hold_credits) begin
            start_hold();
        end else if (MODE_TBL[r] == PROMPT && hold_credits) begin
            end_hold();
        end
        if ((REV_TBL[r] != 0) != en_phase_reverse) begin
            @(negedge clk_adder);
            tdc_valid = 1'b0;
            en_phase_reverse = (REV_TBL[r] != 0);
            repeat (3) idle_cycle();  // through the sync flops.
        end
        repeat (IDLE_TBL[r]) idle_cycle();
        @(negedge clk_adder);
        tdc_word = build_word(LEVEL_TBL[r]);
        tdc_sign = (SIGN_TBL[r] != 0);
        tdc_valid = 1'b1;
        cnt = (REV_TBL[r] != 0) ? NTHM - LEVEL_TBL[r] : LEVEL_TBL[r];
        val = (SIGN_TBL[r] != 0) ? -cnt : cnt;
        if (hold_credits && block_cnt >= CREDIT_MAX + FIFO_DEPTH) begin
            exp_overflow = 1'b1;  // buffer full so the sample is lost.
        end else begin
            exp_q.push_back(sample_t'(val));
            acc_q.push_back(cycle_cnt + 1);
            lat_q.push_back(!hold_credits);
        end
        if (hold_credits) begin
            block_cnt++;
        end
    endtask

    task automatic receive_sample();
        sample_t exp;
        int      acc;
        bit      lat;
        if (avail == 0) begin
            $display("sample_valid went high at %0t with no credit left", $time);
            stop_run();
        end else if (exp_q.size() == 0) begin
            $display("sample_valid went high at %0t with no sample expected", $time);
            stop_run();
        end else begin
            exp = exp_q.pop_front();
            acc = acc_q.pop_front();
            lat = lat_q.pop_front();
            check_sample(exp, sample_out, "sample_out");
            if (lat) begin
                check_latency(LATENCY, cycle_cnt - acc);
            end
            avail--;
            owed++;
        end
    endtask

    // downstream sink returns one credit per cycle.
    always @(negedge clk_adder) begin
        if (rstb) begin
            if (sample_valid) begin
                receive_sample();
            end
            if (credit_return) begin
                avail++;  // taken on the last rising edge.
            end
            if (!hold_credits && owed > 0) begin
                credit_return = 1'b1;
                owed--;
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    always @(posedge clk_adder) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin
        void'($urandom(32'hf714));
        clk_adder = 1'b0;
        rstb = 1'b0;
        tdc_word = '0;
        tdc_sign = 1'b0;
        tdc_valid = 1'b0;
        en_phase_reverse = 1'b0;
        credit_return = 1'b0;
        cycle_cnt = 0;
        cycle_limit = timeout_limit();
        avail = CREDIT_MAX;
        owed = 0;
        hold_credits = 1'b0;
        exp_overflow = 1'b0;
        block_cnt = 0;

        repeat (4) @(negedge clk_adder);
        rstb = 1'b1;
        @(negedge clk_adder);
        check_flag(1'b0, sample_valid, "sample_valid");
        check_flag(1'b0, overflow, "overflow");

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        idle_cycle();
        wait_drained(1'b1);
        idle_cycle();
        check_flag(1'b0, sample_valid, "sample_valid");
        check_flag(exp_overflow, overflow, "overflow");  // sticky.

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- files.f
hdl/adc_slice_pkg.sv
hdl/tdc_capture.sv
hdl/wallace_adder.sv
hdl/adc_retimer.sv
hdl/adc_slice_backend.sv
tb/tb_adc_slice.sv

//--- run_sim.sh
#!/bin/sh
# build and run the adc slice testbench with verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/100ps \
    --top-module tb_adc_slice \
    -f files.f

out=$(./obj_dir/Vtb_adc_slice 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
else
    echo "testbench did not report a pass"
    exit 1
fi
